// ==== Makefile ====
# Verilator build and run of the checkpoint valid-bit testbench
# every variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= tb_chkpt_valid
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing
PASS_LINE ?= ** PASS **

BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: sim clean

# build, run, then decide pass or fail from the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(BIN) | tee $(LOG)
	@if grep -qxF "$(PASS_LINE)" $(LOG); then \
	  echo "simulation passed"; \
	else \
	  echo "simulation failed"; \
	  exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== include/chkpt_defs.svh ====
`ifndef CHKPT_DEFS_SVH
`define CHKPT_DEFS_SVH

// ==============================
// port counts
// ==============================

// update write ports, each one owns a bank in the valid store
// the sweep engine writes one more bank past these, numbered CV_NWR
`define CV_NWR 4

// combinational read ports, one valid bit each
`define CV_NRD 6

// ==============================
// store geometry
// ==============================

// physical registers tracked, also the length of one sweep
`define CV_NPREG 64

// rename checkpoints, one valid bit per checkpoint in every word
// so this is the width of a valid word too
`define CV_NCHECK 16

// the sweep counter and the register index are sized from CV_NPREG
// and the checkpoint index from CV_NCHECK, both powers of two here
// so every index value names a real row or column

`endif

// ==== rtl/chkpt_pkg.sv ====
`include "chkpt_defs.svh"

package chkpt_pkg;

  // ==============================
  // index types
  // ==============================

  typedef logic [$clog2(`CV_NPREG)-1:0]  preg_t;        // physical register number
  typedef logic [$clog2(`CV_NCHECK)-1:0] ckpt_t;        // checkpoint column
  typedef logic [$clog2(`CV_NWR+1)-1:0]  bank_t;        // update banks plus the sweep bank
  typedef logic [`CV_NCHECK-1:0]         valid_word_t;  // one valid bit per checkpoint

  // ==============================
  // sweep command word
  // ==============================

  // top two bits of the command say how the rest is read
  typedef enum logic [1:0] {
    SW_COPY = 2'b00,  // copy one column onto another
    SW_FILL = 2'b01,  // write a constant into one column
    SW_RSV2 = 2'b10,  // acknowledged without touching the store
    SW_RSV3 = 2'b11
  } sweep_op_e;

  typedef struct packed {
    sweep_op_e op;   // same bits as the fill view
    ckpt_t     src;  // column read
    ckpt_t     dst;  // column written
  } sweep_copy_t;

  typedef struct packed {
    sweep_op_e                op;
    ckpt_t                    tgt;  // column written
    logic                     val;  // constant stored in every register
    logic [$bits(ckpt_t)-2:0] pad;  // keeps both views the same width
  } sweep_fill_t;

  typedef union packed {
    sweep_copy_t cp;
    sweep_fill_t fl;
  } sweep_cmd_u;

endpackage

// ==== rtl/chkpt_valid_top.sv ====
`timescale 1ns/100ps
`include "chkpt_defs.svh"

// checkpoint valid-bit store with its sweep engine
module chkpt_valid_top import chkpt_pkg::*; (
  input  logic                clka,
  input  logic                rst,
  // update writes
  input  logic [`CV_NWR-1:0]  wr,
  input  ckpt_t [`CV_NWR-1:0] wc,
  input  preg_t [`CV_NWR-1:0] wa,
  input  logic [`CV_NWR-1:0]  i,
  // reads
  input  ckpt_t [`CV_NRD-1:0] rc,
  input  preg_t [`CV_NRD-1:0] ra,
  output logic [`CV_NRD-1:0]  o,
  // sweep commands, four-phase handshake
  input  sweep_cmd_u          cmd,
  input  logic                cmd_req,
  output logic                cmd_ack,
  output logic                busy   // init fill or command in flight
);

  logic  cnt_clr;
  logic  cnt_en;
  preg_t cnt_idx;   // also the sweep write address
  logic  cnt_last;
  logic  sw_we;
  logic  sw_copy;
  ckpt_t sw_src;
  ckpt_t sw_dst;
  logic  sw_val;
  logic  sw_all;

  sweep_fsm u_fsm (
    .clka     (clka),
    .rst      (rst),
    .cmd      (cmd),
    .cmd_req  (cmd_req),
    .cnt_last (cnt_last),
    .cmd_ack  (cmd_ack),
    .busy     (busy),
    .cnt_clr  (cnt_clr),
    .cnt_en   (cnt_en),
    .sw_we    (sw_we),
    .sw_copy  (sw_copy),
    .sw_src   (sw_src),
    .sw_dst   (sw_dst),
    .sw_val   (sw_val),
    .sw_all   (sw_all)
  );

  sweep_counter u_cnt (
    .clka     (clka),
    .rst      (rst),
    .cnt_clr  (cnt_clr),
    .cnt_en   (cnt_en),
    .cnt_idx  (cnt_idx),
    .cnt_last (cnt_last)
  );

  valid_banks u_banks (
    .clka    (clka),
    .rst     (rst),
    .wr      (wr),
    .wc      (wc),
    .wa      (wa),
    .i       (i),
    .sw_we   (sw_we),
    .sw_copy (sw_copy),
    .sw_src  (sw_src),
    .sw_dst  (sw_dst),
    .sw_val  (sw_val),
    .sw_addr (cnt_idx),
    .sw_all  (sw_all),
    .rc      (rc),
    .ra      (ra),
    .o       (o)
  );

endmodule

// ==== rtl/sweep_counter.sv ====
`timescale 1ns/100ps
`include "chkpt_defs.svh"

// walks the register index from 0 up to the last physical register
// the index sticks at the last register until cleared, it never wraps
module sweep_counter import chkpt_pkg::*; (
  input  logic  clka,
  input  logic  rst,
  input  logic  cnt_clr,   // back to register 0, wins over cnt_en
  input  logic  cnt_en,    // step one register per cycle
  output preg_t cnt_idx,   // register being swept this cycle
  output logic  cnt_last   // cnt_idx is the last register
);

  localparam preg_t LAST_IDX = preg_t'(`CV_NPREG - 1);

  // ==============================
  // index register
  // ==============================

  always_ff @(posedge clka) begin
    if (rst) begin
      cnt_idx <= '0;                         // the initial fill starts at register 0
    end else if (cnt_clr) begin
      cnt_idx <= '0;
    end else if (cnt_en && !cnt_last) begin  // hold at the end instead of wrapping
      cnt_idx <= cnt_idx + preg_t'(1);
    end
  end

  // the FSM ends the sweep on the cycle this is high
  assign cnt_last = (cnt_idx == LAST_IDX);

endmodule

// ==== rtl/sweep_fsm.sv ====
`timescale 1ns/100ps

// sequences the sweep bank writes
// init sets every bit to one right after reset, then commands arrive
// over a four-phase req/ack handshake and each runs one full sweep
module sweep_fsm import chkpt_pkg::*; (
  input  logic       clka,
  input  logic       rst,
  input  sweep_cmd_u cmd,       // stable while cmd_req is high
  input  logic       cmd_req,
  input  logic       cnt_last,  // the counter sits on the last register
  output logic       cmd_ack,
  output logic       busy,
  output logic       cnt_clr,
  output logic       cnt_en,
  output logic       sw_we,     // write the sweep bank at the counter index
  output logic       sw_copy,   // copy when high, fill when low
  output ckpt_t      sw_src,
  output ckpt_t      sw_dst,
  output logic       sw_val,
  output logic       sw_all     // fill every column, only during init
);

  localparam logic [1:0] ST_INIT  = 2'd0;  // reset fill with ones
  localparam logic [1:0] ST_IDLE  = 2'd1;  // waiting for cmd_req
  localparam logic [1:0] ST_SWEEP = 2'd2;  // one write per register
  localparam logic [1:0] ST_HOLD  = 2'd3;  // ack high until req drops

  logic [1:0] state;
  logic       copy_q;  // latched command fields
  ckpt_t      src_q;
  ckpt_t      dst_q;
  logic       val_q;

  // ==============================
  // state register
  // ==============================

  always_ff @(posedge clka) begin
    if (rst) begin
      state <= ST_INIT;
    end else begin
      case (state)
        ST_INIT: if (cnt_last) state <= ST_IDLE;  // last register written on this edge
        ST_IDLE: begin
          if (cmd_req) begin
            // reserved codes skip the sweep and go straight to the ack
            if (cmd.cp.op == SW_COPY || cmd.fl.op == SW_FILL) state <= ST_SWEEP;
            else state <= ST_HOLD;
          end
        end
        ST_SWEEP: if (cnt_last) state <= ST_HOLD;  // ack rises with the last write
        ST_HOLD: if (!cmd_req) state <= ST_IDLE;   // ack falls one cycle after req does
        default: state <= ST_INIT;
      endcase
    end
  end

  // ==============================
  // command decode
  // ==============================

  // the op bits sit in the same place in both views, so either view
  // selects which view carries the rest of the fields
  always_ff @(posedge clka) begin
    if (state == ST_IDLE && cmd_req) begin
      case (cmd.cp.op)
        SW_COPY: begin
          copy_q <= 1'b1;
          src_q  <= cmd.cp.src;
          dst_q  <= cmd.cp.dst;
        end
        SW_FILL: begin
          copy_q <= 1'b0;
          dst_q  <= cmd.fl.tgt;  // fill target goes out on the same port as the copy destination
          val_q  <= cmd.fl.val;
        end
        default: copy_q <= 1'b0;  // nothing is written for these
      endcase
    end
  end

  // ==============================
  // outputs
  // ==============================

  assign busy    = (state != ST_IDLE);
  assign cmd_ack = (state == ST_HOLD);
  assign cnt_clr = (state == ST_IDLE);  // every sweep starts from register 0
  assign cnt_en  = (state == ST_INIT) || (state == ST_SWEEP);

  // the FSM sits in init during reset as well, and the store must see no
  // writes until the first cycle after rst falls
  assign sw_we   = ((state == ST_INIT) && !rst) || (state == ST_SWEEP);
  assign sw_all  = (state == ST_INIT);
  assign sw_copy = (state == ST_SWEEP) && copy_q;
  assign sw_val  = (state == ST_INIT) ? 1'b1 : val_q;  // init fills with ones
  assign sw_src  = src_q;
  assign sw_dst  = dst_q;

endmodule

// ==== rtl/valid_banks.sv ====
`timescale 1ns/100ps
`include "chkpt_defs.svh"

// multiported store of checkpoint valid bits, one word per physical register
// every update port owns a bank, the sweep engine owns one more, and a live
// value table remembers which bank holds the newest word of each register
module valid_banks import chkpt_pkg::*; (
  input  logic                     clka,
  input  logic                     rst,
  // update writes, one bit of one checkpoint per port
  input  logic [`CV_NWR-1:0]       wr,
  input  ckpt_t [`CV_NWR-1:0]      wc,
  input  preg_t [`CV_NWR-1:0]      wa,
  input  logic [`CV_NWR-1:0]       i,
  // sweep write, one register per cycle
  input  logic                     sw_we,
  input  logic                     sw_copy,
  input  ckpt_t                    sw_src,
  input  ckpt_t                    sw_dst,
  input  logic                     sw_val,
  input  preg_t                    sw_addr,
  input  logic                     sw_all,
  // reads
  input  ckpt_t [`CV_NRD-1:0]      rc,
  input  preg_t [`CV_NRD-1:0]      ra,
  output logic [`CV_NRD-1:0]       o
);

  localparam int    NBANK      = `CV_NWR + 1;
  localparam bank_t SWEEP_BANK = bank_t'(`CV_NWR);  // last bank, lowest write priority

  valid_word_t mem [NBANK][`CV_NPREG];  // bank storage
  bank_t       lvt [`CV_NPREG];         // newest bank per register

  valid_word_t upd_cur [`CV_NWR];  // merged word each update port starts from
  valid_word_t upd_nxt [`CV_NWR];  // same word with the port's bit replaced
  valid_word_t sw_cur;
  valid_word_t sw_nxt;

  // returns w with bit pos forced to b
  function automatic valid_word_t put_bit(input valid_word_t w, input ckpt_t pos,
                                          input logic b);
    valid_word_t r;
    r      = w;
    r[pos] = b;
    return r;
  endfunction

  // ==============================
  // read-modify-write merge
  // ==============================

  // each port reads whichever bank last wrote its register, so the other
  // checkpoint bits of that register carry over unchanged
  always_comb begin
    for (int p = 0; p < `CV_NWR; p++) begin
      upd_cur[p] = mem[lvt[wa[p]]][wa[p]];
      upd_nxt[p] = put_bit(upd_cur[p], wc[p], i[p]);
    end
  end

  always_comb begin
    sw_cur = mem[lvt[sw_addr]][sw_addr];
    if (sw_all) begin
      sw_nxt = {`CV_NCHECK{sw_val}};                     // whole word, initial fill
    end else if (sw_copy) begin
      sw_nxt = put_bit(sw_cur, sw_dst, sw_cur[sw_src]);  // source column onto destination
    end else begin
      sw_nxt = put_bit(sw_cur, sw_dst, sw_val);          // one column set to the constant
    end
  end

  // ==============================
  // bank writes
  // ==============================

  // the sweep bank is written at the counter index, every other bank only
  // by the update port that owns it
  always_ff @(posedge clka) begin
    if (sw_we) mem[SWEEP_BANK][sw_addr] <= sw_nxt;
    for (int p = 0; p < `CV_NWR; p++) begin
      if (wr[p]) mem[p][wa[p]] <= upd_nxt[p];  // every port writes only its own bank
    end
  end

  // later assignments win, so the sweep goes first and then the ports in
  // rising order, leaving the highest-numbered writer of a register in the table
  always_ff @(posedge clka) begin
    if (rst) begin
      for (int r = 0; r < `CV_NPREG; r++) lvt[r] <= SWEEP_BANK;
    end else begin
      if (sw_we) lvt[sw_addr] <= SWEEP_BANK;
      for (int p = 0; p < `CV_NWR; p++) begin
        if (wr[p]) lvt[wa[p]] <= bank_t'(p);
      end
    end
  end

  // ==============================
  // read ports
  // ==============================

  // reads see the state after the last edge, a write at edge k shows here
  // right after edge k
  always_comb begin
    for (int r = 0; r < `CV_NRD; r++) begin
      if (rst) begin
        o[r] = 1'b1;  // every register counts as valid in reset
      end else begin
        o[r] = mem[lvt[ra[r]]][ra[r]][rc[r]];
      end
    end
  end

endmodule

// ==== sources.f ====
+incdir+include
rtl/chkpt_pkg.sv
rtl/sweep_counter.sv
rtl/sweep_fsm.sv
rtl/valid_banks.sv
rtl/chkpt_valid_top.sv
tests/tb_chkpt_valid.sv

// ==== tests/tb_chkpt_valid.sv ====
`timescale 1ns/100ps
`include "chkpt_defs.svh"

// testbench for the checkpoint valid-bit store
// a shadow array follows every write and a separate process checks the read ports
module tb_chkpt_valid import chkpt_pkg::*; ();

  localparam int PERIOD_NS     = 100;
  localparam int RANDOM_CYCLES = 200;  // update-only stretch before the sweeps
  localparam int SWEEPS        = 4;    // copy, fill 0, fill 1, reserved op
  localparam int READ_PASSES   = 5;    // full read-outs of the store
  localparam int TOTAL_CYCLES  = 2 + `CV_NPREG + SWEEPS * (`CV_NPREG + 4) + RANDOM_CYCLES
                               + READ_PASSES * (`CV_NPREG * `CV_NCHECK / `CV_NRD + 1)
                               + 3 * `CV_NPREG;
  localparam int WATCHDOG_NS   = 2 * TOTAL_CYCLES * PERIOD_NS;  // twice the expected run

  logic                clka;
  logic                rst;
  logic [`CV_NWR-1:0]  wr;
  ckpt_t [`CV_NWR-1:0] wc;
  preg_t [`CV_NWR-1:0] wa;
  logic [`CV_NWR-1:0]  i;
  ckpt_t [`CV_NRD-1:0] rc;
  preg_t [`CV_NRD-1:0] ra;
  logic [`CV_NRD-1:0]  o;
  sweep_cmd_u          cmd;
  logic                cmd_req;
  logic                cmd_ack;
  logic                busy;

  valid_word_t shadow [`CV_NPREG];  // expected word of every register
  int          sw_left;             // sweep writes the model still has to apply
  int          sw_next;             // register the sweep writes at the next edge
  logic        m_copy;              // latched command of the model
  ckpt_t       m_src;
  ckpt_t       m_dst;
  logic        m_val;
  logic        chk_en;              // read ports are compared while high
  int          n_checks;
  int          n_errors;
  integer      seed;

  chkpt_valid_top DUT (
    .clka (clka), .rst (rst),
    .wr (wr), .wc (wc), .wa (wa), .i (i),
    .rc (rc), .ra (ra), .o (o),
    .cmd (cmd), .cmd_req (cmd_req), .cmd_ack (cmd_ack), .busy (busy)
  );

  initial begin
    clka = 1'b0;
    forever #(PERIOD_NS / 2) clka = ~clka;
  end

  // ==============================
  // reference model
  // ==============================

  // expected valid bit of one register in one checkpoint
  function automatic logic valid_ref(input ckpt_t ckpt, input preg_t preg);
    return shadow[preg][ckpt];
  endfunction

  // applies one clock edge to the shadow, using the inputs held across that edge
  task automatic model_edge();
    valid_word_t nxt [`CV_NPREG];
    valid_word_t w;
    nxt = shadow;
    if (sw_left > 0) begin  // the sweep bank ranks lowest, so it goes first
      w = shadow[sw_next];
      w[m_dst] = m_copy ? shadow[sw_next][m_src] : m_val;
      nxt[sw_next] = w;
      sw_next++;
      sw_left--;
    end
    for (int p = 0; p < `CV_NWR; p++) begin
      if (wr[p]) begin
        w = shadow[wa[p]];  // each port starts from the word before the edge
        w[wc[p]] = i[p];
        nxt[wa[p]] = w;     // a later port overwrites the whole word
      end
    end
    shadow = nxt;
  endtask

  // one clock, then the shadow catches up on the falling edge
  task automatic next_cycle();
    @(posedge clka);
    @(negedge clka);
    model_edge();
  endtask

  // ==============================
  // checking
  // ==============================

  task automatic compare(input logic [31:0] got, input logic [31:0] exp, input string what);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("error at %0t: %s, got %0h expected %0h", $time, what, got, exp);
    end
  endtask

  // reads sampled just before the edge, when ra, rc and the store are all settled
  always @(posedge clka) begin
    logic exp_bit;
    if (chk_en) begin
      for (int r = 0; r < `CV_NRD; r++) begin
        exp_bit = rst ? 1'b1 : valid_ref(rc[r], ra[r]);  // everything reads valid in reset
        compare(32'(o[r]), 32'(exp_bit),
                $sformatf("read port %0d reg %0d ckpt %0d", r, ra[r], rc[r]));
      end
    end
  end

  // ==============================
  // stimulus tasks
  // ==============================

  task automatic drive_random_reads();
    for (int r = 0; r < `CV_NRD; r++) begin
      ra[r] = preg_t'($random(seed));
      rc[r] = ckpt_t'($random(seed));
    end
  endtask

  // one cycle of writes on every port, distinct registers unless collide is set
  task automatic update_cycle(input int avoid_reg, input int avoid_col, input bit collide);
    bit    used [`CV_NPREG];
    preg_t last_wa [`CV_NWR];
    int    a;
    int    c;
    int    p0;
    int    p1;
    used = '{default: 1'b0};
    if (avoid_reg >= 0) used[avoid_reg] = 1'b1;  // register the sweep writes this edge
    for (int p = 0; p < `CV_NWR; p++) begin
      last_wa[p] = wa[p];
      do a = int'($unsigned($random(seed)) % `CV_NPREG); while (used[a]);
      used[a] = 1'b1;
      do c = int'($unsigned($random(seed)) % `CV_NCHECK); while (c == avoid_col);
      wa[p] = preg_t'(a);
      wc[p] = ckpt_t'(c);
      i[p]  = 1'($random(seed));
      wr[p] = 1'b1;
    end
    if (collide) begin
      p0 = int'($unsigned($random(seed)) % `CV_NWR);
      p1 = (p0 + 1 + int'($unsigned($random(seed)) % (`CV_NWR - 1))) % `CV_NWR;
      wa[p1] = wa[p0];  // two ports on one register
    end
    // the first read ports look back at what was written on the last edge
    for (int r = 0; r < `CV_NRD; r++) begin
      if (r < `CV_NWR) ra[r] = last_wa[r];
      else ra[r] = preg_t'($random(seed));
      rc[r] = ckpt_t'($random(seed));
    end
    next_cycle();
  endtask

  // walks every register and checkpoint through the read ports
  task automatic read_every_bit();
    int n;
    wr = '0;
    n  = 0;
    while (n < `CV_NPREG * `CV_NCHECK) begin
      for (int r = 0; r < `CV_NRD; r++) begin
        ra[r] = preg_t'(((n + r) / `CV_NCHECK) % `CV_NPREG);
        rc[r] = ckpt_t'((n + r) % `CV_NCHECK);
      end
      next_cycle();
      n += `CV_NRD;
    end
  endtask

  // reads the source and destination column side by side on port pairs
  // both must show the source bit that the model holds for the register
  task automatic check_copy_columns(input ckpt_t src, input ckpt_t dst);
    int reg_no;
    wr = '0;
    for (int base = 0; base < `CV_NPREG; base += `CV_NRD / 2) begin
      for (int k = 0; k < `CV_NRD / 2; k++) begin
        reg_no        = (base + k) % `CV_NPREG;
        ra[2 * k]     = preg_t'(reg_no);
        rc[2 * k]     = src;
        ra[2 * k + 1] = preg_t'(reg_no);
        rc[2 * k + 1] = dst;
      end
      next_cycle();  // o is settled on the falling edge
      for (int k = 0; k < `CV_NRD / 2; k++) begin
        reg_no = (base + k) % `CV_NPREG;
        compare(32'(o[2 * k]), 32'(valid_ref(src, preg_t'(reg_no))),
                $sformatf("reg %0d ckpt %0d source of copy", reg_no, src));
        compare(32'(o[2 * k + 1]), 32'(valid_ref(src, preg_t'(reg_no))),
                $sformatf("reg %0d ckpt %0d after copy from %0d", reg_no, dst, src));
      end
    end
  endtask

  task automatic check_fill_column(input ckpt_t col, input logic val);
    wr = '0;
    for (int base = 0; base < `CV_NPREG; base += `CV_NRD) begin
      for (int r = 0; r < `CV_NRD; r++) begin
        ra[r] = preg_t'((base + r) % `CV_NPREG);
        rc[r] = col;
      end
      next_cycle();
      for (int r = 0; r < `CV_NRD; r++) begin
        compare(32'(o[r]), 32'(val), $sformatf("reg %0d ckpt %0d after fill", ra[r], col));
      end
    end
  endtask

  // full four-phase handshake, latency counted from the edge that samples req
  task automatic run_command(input sweep_cmd_u c, input int latency, input bit updates,
                             input int avoid_col);
    int cnt;
    cmd     = c;
    cmd_req = 1'b1;
    wr      = '0;
    drive_random_reads();
    next_cycle();
    if (c.cp.op == SW_COPY || c.cp.op == SW_FILL) begin
      m_copy  = (c.cp.op == SW_COPY);
      m_src   = c.cp.src;
      m_dst   = m_copy ? c.cp.dst : c.fl.tgt;
      m_val   = c.fl.val;
      sw_left = `CV_NPREG;  // register 0 goes on the next edge
      sw_next = 0;
    end
    cnt = 0;
    while (cmd_ack !== 1'b1 && cnt < `CV_NPREG + 8) begin
      if (updates) begin
        update_cycle((sw_left > 0) ? sw_next : -1, avoid_col, 1'b0);
      end else begin
        wr = '0;
        drive_random_reads();
        next_cycle();
      end
      cnt++;
    end
    if (cmd_ack !== 1'b1) begin
      n_errors++;
      $display("cmd_ack did not rise within %0d cycles of the request", cnt);
    end
    compare(cnt, latency, "cycles from request to ack");
    wr      = '0;
    cmd_req = 1'b0;
    next_cycle();
    compare(32'(cmd_ack), 32'h0, "cmd_ack one cycle after cmd_req fell");
    compare(32'(busy), 32'h0, "busy after the command");
  endtask

  // ==============================
  // test sequence
  // ==============================

  initial begin : stimulus
    sweep_cmd_u c;
    ckpt_t      src;
    ckpt_t      dst;
    ckpt_t      col;
    int         cnt;
    seed     = 32'h7868_c3ff;
    rst      = 1'b1;
    wr       = '0;
    wc       = '0;
    wa       = '0;
    i        = '0;
    rc       = '0;
    ra       = '0;
    cmd      = '0;
    cmd_req  = 1'b0;
    chk_en   = 1'b1;  // reads in reset are checked too
    sw_left  = 0;
    sw_next  = 0;
    n_checks = 0;
    n_errors = 0;
    for (int r = 0; r < `CV_NPREG; r++) shadow[r] = '1;
    for (int n = 0; n < 2; n++) begin
      drive_random_reads();
      next_cycle();
      compare(32'(busy), 32'h1, "busy in reset");
      compare(32'(cmd_ack), 32'h0, "cmd_ack in reset");
    end
    rst    = 1'b0;
    chk_en = 1'b0;  // the store is only partly filled until busy falls
    cnt    = 0;
    while (busy === 1'b1 && cnt < `CV_NPREG + 8) begin
      next_cycle();
      cnt++;
    end
    compare(cnt, `CV_NPREG, "cycles of the initial fill");
    chk_en = 1'b1;
    read_every_bit();

    for (int n = 0; n < RANDOM_CYCLES; n++) begin
      update_cycle(-1, -1, (n % 4) == 3);  // every fourth cycle has a collision
    end
    read_every_bit();

    src = ckpt_t'($random(seed));
    do dst = ckpt_t'($random(seed)); while (dst == src);
    c       = '0;
    c.cp.op  = SW_COPY;
    c.cp.src = src;
    c.cp.dst = dst;
    run_command(c, `CV_NPREG, 1'b0, -1);
    check_copy_columns(src, dst);
    read_every_bit();

    col = ckpt_t'($random(seed));
    c       = '0;
    c.fl.op  = SW_FILL;
    c.fl.tgt = col;
    c.fl.val = 1'b0;
    run_command(c, `CV_NPREG, 1'b1, int'(col));  // updates keep off the filled column
    check_fill_column(col, 1'b0);
    c.fl.val = 1'b1;
    run_command(c, `CV_NPREG, 1'b1, int'(col));
    check_fill_column(col, 1'b1);
    read_every_bit();

    c      = '0;
    c.cp.op = SW_RSV2;  // acknowledged straight away, store untouched
    run_command(c, 0, 1'b0, -1);
    read_every_bit();

    $display("summary: %0d checks, %0d errors", n_checks, n_errors);
    if (n_errors == 0) $display("** PASS **");
    else $display("** FAIL **");
    $finish;
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
    $display("** FAIL **");
    $finish;
  end

endmodule
